// ==== dv/piton_bridge_assert.sv ====
// concurrent checks on the bridge request handshake and the done pulse, with bind
`include "piton_config.svh"

module piton_bridge_assert (
    input logic                       clk,
    input logic                       nrst,
    input logic                       op,
    input logic                       core_l15_val,
    input logic                       l15_core_ack,
    input logic                       l15_core_header_ack,
    input logic [`PITON_RQTYPE_W-1:0] core_l15_rqtype,
    input logic [`PITON_SIZE_W-1:0]   core_l15_size,
    input logic [`PITON_ADDR_W-1:0]   core_l15_address,
    input logic [`PITON_DATA_W-1:0]   core_l15_data,
    input logic                       done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic held;

    // request offered but not taken this cycle
    assign held = core_l15_val && !(l15_core_ack && l15_core_header_ack);

    req_stable: assert property (@(posedge clk) disable iff (!nrst)
        held |=> core_l15_val && $stable(core_l15_rqtype) && $stable(core_l15_size) &&
                 $stable(core_l15_address) && $stable(core_l15_data))
        else $error("request fields changed before acceptance");

    // val stays low out of reset until a core op is captured
    val_from_op: assert property (@(posedge clk) disable iff (!nrst)
        $rose(core_l15_val) |-> $past(op))
        else $error("request valid raised without a core op");

    // completion is a single cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else $error("done held for more than one cycle");

endmodule

bind piton_core_bridge piton_bridge_assert u_piton_bridge_assert (
    .clk (clk), .nrst (nrst), .op (op), .core_l15_val (core_l15_val),
    .l15_core_ack (l15_core_ack), .l15_core_header_ack (l15_core_header_ack),
    .core_l15_rqtype (core_l15_rqtype), .core_l15_size (core_l15_size),
    .core_l15_address (core_l15_address), .core_l15_data (core_l15_data), .done (done)
);

// ==== dv/piton_clk_gen.sv ====
// testbench clock and active-low reset generator
module piton_clk_gen (
    output logic clk,
    output logic nrst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over three rising edges
    initial begin
        nrst = 1'b0;
        repeat (3) @(posedge clk);
        #1 nrst = 1'b1;
    end

endmodule

// ==== dv/piton_tb.sv ====
// testbench: l1.5 responder model, core stimulus, reference model, checks, timeout
module piton_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 300 * 12;

    logic        clk;
    logic        nrst;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        rd;
    logic [3:0]  bw;
    logic        op;
    logic [31:0] rdata;
    logic        done;
    logic        err;
    logic        core_l15_val;
    logic [5:0]  core_l15_rqtype;
    logic [2:0]  core_l15_size;
    logic [31:0] core_l15_address;
    logic [31:0] core_l15_data;
    logic        l15_core_ack;
    logic        l15_core_header_ack;
    logic        l15_core_val;
    logic [3:0]  l15_core_returntype;
    logic [31:0] l15_core_data_0;
    logic [31:0] l15_core_data_1;
    logic [31:0] l15_core_data_2;
    logic [31:0] l15_core_data_3;

    // cache copy holds big-endian words, shadow holds the core view
    logic [31:0] cache_mem [0:63];
    logic [31:0] shadow [0:63];
    logic [3:0]  be_tab [0:7] = '{4'hf, 4'h3, 4'hc, 4'h1, 4'h2, 4'h4, 4'h8, 4'h5};
    logic [31:0] m_rnd;
    logic [31:0] s_rnd;
    logic [31:0] s_rnd2;
    logic [5:0]  line_idx;
    logic        err_mode = 1'b0;
    logic        e_err;
    logic        e_chk;
    logic [31:0] e_data;
    int          seed = 33436;
    int          accept_cnt = 0;
    int          done_cnt = 0;
    int          cycles = 0;
    bit          exp_err_q [$];
    bit          exp_chk_q [$];
    logic [31:0] exp_data_q [$];

    piton_clk_gen u_piton_clk_gen (.clk (clk), .nrst (nrst));

    piton_core_top u_piton_core_top (.*);

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH %0t %s: got %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR %0t: %s", $time, why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] be);
        logic [31:0] r;
        r = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) r[8*i +: 8] = d[8*i +: 8];
        end
        return r;
    endfunction

    function automatic logic [2:0] expected_size(input logic [3:0] be);
        case (be)
            4'b1111, 4'b0000: return 3'd3;
            4'b0011, 4'b1100: return 3'd2;
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return 3'd1;
            default: return 3'd0;
        endcase
    endfunction

    // reference: core-order word at the addressed location
    function automatic logic [31:0] expected_rdata(input logic [31:0] a);
        return shadow[a[7:2]];
    endfunction

    // l1.5 responder, one request at a time
    initial begin
        l15_core_ack = 1'b0;
        l15_core_header_ack = 1'b0;
        l15_core_val = 1'b0;
        l15_core_returntype = 4'd0;
        l15_core_data_0 = '0;
        l15_core_data_1 = '0;
        l15_core_data_2 = '0;
        l15_core_data_3 = '0;
        for (int k = 0; k < 64; k++) begin
            shadow[k] = (32'h9e37_79b9 * (k + 1)) ^ (k << 20);
            cache_mem[k] = swap_bytes(shadow[k]);
        end
        forever begin
            @(posedge clk);
            if (core_l15_val === 1'b1) begin
                m_rnd = $random(seed);
                repeat (m_rnd % 4) @(posedge clk);
                #1;
                l15_core_ack = 1'b1;
                l15_core_header_ack = 1'b1;
                @(posedge clk);
                accept_cnt++;
                line_idx = core_l15_address[7:2];
                check_eq(core_l15_address, addr, "request address");
                check_eq({26'h0, core_l15_rqtype}, {31'h0, bw != 4'b0}, "request type");
                check_eq({29'h0, core_l15_size}, {29'h0, expected_size(bw)}, "request size");
                if (bw != 4'b0) begin
                    check_eq(core_l15_data, swap_bytes(wdata), "store payload");
                    for (int lane = 0; lane < 4; lane++) begin
                        if (bw[lane]) cache_mem[line_idx][31-8*lane -: 8] =
                            core_l15_data[31-8*lane -: 8];
                    end
                end
                m_rnd = $random(seed);
                #1;
                l15_core_ack = 1'b0;
                l15_core_header_ack = 1'b0;
                repeat (m_rnd % 5) @(posedge clk);
                #1;
                l15_core_val = 1'b1;
                if (err_mode) l15_core_returntype = piton_pkg::ERR_RET;
                else if (bw != 4'b0) l15_core_returntype = piton_pkg::ST_ACK;
                else l15_core_returntype = piton_pkg::LOAD_RET;
                l15_core_data_0 = cache_mem[{line_idx[5:2], 2'd0}];
                l15_core_data_1 = cache_mem[{line_idx[5:2], 2'd1}];
                l15_core_data_2 = cache_mem[{line_idx[5:2], 2'd2}];
                l15_core_data_3 = cache_mem[{line_idx[5:2], 2'd3}];
                @(posedge clk);
                #1;
                l15_core_val = 1'b0;
            end
        end
    end

    // completion compare against queued expectations
    always @(posedge clk) begin
        if (done === 1'b1) begin
            done_cnt++;
            if (exp_err_q.size() == 0) begin
                abort_run("done pulse without an outstanding operation");
            end else begin
                e_err = exp_err_q.pop_front();
                e_chk = exp_chk_q.pop_front();
                e_data = exp_data_q.pop_front();
                check_eq({31'h0, err}, {31'h0, e_err}, "error flag");
                if (e_chk) check_eq(rdata, e_data, "load data");
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) abort_run("timeout, operations did not finish in time");
    end

    task automatic do_op(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        int acc0;
        int done0;
        acc0 = accept_cnt;
        done0 = done_cnt;
        exp_err_q.push_back(err_mode);
        exp_chk_q.push_back(be == 4'b0000 && !err_mode);
        exp_data_q.push_back(expected_rdata(a));
        if (be != 4'b0000) shadow[a[7:2]] = merge_bytes(shadow[a[7:2]], d, be);
        addr = a;
        wdata = d;
        bw = be;
        rd = (be == 4'b0000);
        op = 1'b1;
        @(posedge clk);
        while (done !== 1'b1) @(posedge clk);
        #1;
        op = 1'b0;
        check_eq(accept_cnt, acc0 + 1, "accepted requests for one op");
        check_eq(done_cnt, done0 + 1, "done pulses for one op");
    endtask

    initial begin
        addr = '0;
        wdata = '0;
        rd = 1'b0;
        bw = 4'b0;
        op = 1'b0;
        wait (nrst === 1'b1);
        // nothing issued before the first op
        repeat (4) begin
            @(posedge clk);
            check_eq({31'h0, core_l15_val}, 32'h0, "val low after reset");
            check_eq({31'h0, done}, 32'h0, "done low after reset");
        end
        #1;
        do_op(32'h1000_0040, 32'h1122_3344, 4'b1111);
        do_op(32'h1000_0040, 32'h0, 4'b0000);
        // halfword and byte merges
        do_op(32'h1000_0044, 32'haabb_ccdd, 4'b0011);
        do_op(32'h1000_0044, 32'h5566_7788, 4'b1100);
        do_op(32'h1000_0044, 32'h0, 4'b0000);
        for (int b = 0; b < 4; b++) begin
            do_op(32'h1000_0048, 32'hf0e1_d2c3 + b, 4'b0001 << b);
        end
        do_op(32'h1000_0048, 32'h0, 4'b0000);
        // every word of one line
        for (int w = 0; w < 4; w++) begin
            do_op(32'h2000_0080 + 4 * w, 32'h0, 4'b0000);
        end
        repeat (100) begin
            s_rnd = $random(seed);
            s_rnd2 = $random(seed);
            do_op({s_rnd[31:7], 1'b0, s_rnd[5:2], 2'b00}, s_rnd2,
                  s_rnd2[3] ? 4'b0000 : be_tab[s_rnd2[2:0]]);
        end
        err_mode = 1'b1;
        do_op(32'h3000_0010, 32'h0, 4'b0000);
        err_mode = 1'b0;
        do_op(32'h3000_0010, 32'h0, 4'b0000);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module piton_tb -f verilog.f -o piton_sim

# simulator status is ignored here, the log decides
./obj_dir/piton_sim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== source/piton_config.svh ====
// field widths of the l1.5 cache port and the core memory port
`ifndef PITON_CONFIG_SVH
`define PITON_CONFIG_SVH

// core side, one word per operation
`define PITON_ADDR_W 32
`define PITON_DATA_W 32

// byte write enables, one per data byte
`define PITON_BE_W (`PITON_DATA_W / 8)

// request type field of the l1.5 header
`define PITON_RQTYPE_W 6

// return type field of the l1.5 response
`define PITON_RTYPE_W 4

// message data size field
`define PITON_SIZE_W 3

`endif

// ==== source/piton_core_bridge.sv ====
// bridge FSM: request holding registers, l1.5 handshake, core completion
`include "piton_config.svh"

module piton_core_bridge (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     op,
    input  logic [`PITON_ADDR_W-1:0] addr,
    input  piton_pkg::rqtype_e       enc_rqtype,
    input  piton_pkg::msg_size_e     enc_size,
    input  logic [`PITON_DATA_W-1:0] enc_data,
    input  logic                     l15_core_ack,
    input  logic                     l15_core_header_ack,
    input  logic                     l15_core_val,
    input  logic [`PITON_DATA_W-1:0] resp_word,
    input  logic                     resp_err,
    output logic                     core_l15_val,
    output piton_pkg::rqtype_e       core_l15_rqtype,
    output piton_pkg::msg_size_e     core_l15_size,
    output logic [`PITON_ADDR_W-1:0] core_l15_address,
    output logic [`PITON_DATA_W-1:0] core_l15_data,
    output logic [`PITON_DATA_W-1:0] rdata,
    output logic                     done,
    output logic                     err
);

    piton_pkg::bridge_state_e state;

    logic load_req;
    logic req_fire;
    logic resp_fire;

    // capture a new operation only from idle
    assign load_req = (state == piton_pkg::S_REQ) && op;

    // header and payload both taken in the same cycle
    assign req_fire = (state == piton_pkg::S_SEND) && core_l15_val &&
                      l15_core_ack && l15_core_header_ack;

    assign resp_fire = (state == piton_pkg::S_WAIT) && l15_core_val;

    // single cycle completion pulse
    assign done = (state == piton_pkg::S_RESP);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state        <= piton_pkg::S_REQ;
            core_l15_val <= 1'b0;
            err          <= 1'b0;
        end else begin
            case (state)
                piton_pkg::S_REQ: begin
                    if (load_req) begin
                        state        <= piton_pkg::S_SEND;
                        core_l15_val <= 1'b1;
                    end
                end
                piton_pkg::S_SEND: begin
                    // hold val and fields under back-pressure
                    if (req_fire) begin
                        state        <= piton_pkg::S_WAIT;
                        core_l15_val <= 1'b0;
                    end
                end
                piton_pkg::S_WAIT: begin
                    if (resp_fire) begin
                        state <= piton_pkg::S_RESP;
                        err   <= resp_err;
                    end
                end
                default: begin
                    state <= piton_pkg::S_REQ;
                end
            endcase
        end
    end

    // request fields frozen from capture until the next op
    always_ff @(posedge clk) begin
        if (load_req) begin
            core_l15_address <= addr;
            core_l15_rqtype  <= enc_rqtype;
            core_l15_size    <= enc_size;
            core_l15_data    <= enc_data;
        end
        if (resp_fire) begin
            rdata <= resp_word;
        end
    end

endmodule

// ==== source/piton_core_top.sv ====
// top level: core memory port to l1.5 request and response ports
`include "piton_config.svh"

module piton_core_top (
    input  logic                      clk,
    input  logic                      nrst,
    // core memory stage
    input  logic [`PITON_ADDR_W-1:0]  addr,
    input  logic [`PITON_DATA_W-1:0]  wdata,
    input  logic                      rd,
    input  logic [`PITON_BE_W-1:0]    bw,
    input  logic                      op,
    output logic [`PITON_DATA_W-1:0]  rdata,
    output logic                      done,
    output logic                      err,
    // l1.5 request
    output logic                      core_l15_val,
    output logic [`PITON_RQTYPE_W-1:0] core_l15_rqtype,
    output logic [`PITON_SIZE_W-1:0]  core_l15_size,
    output logic [`PITON_ADDR_W-1:0]  core_l15_address,
    output logic [`PITON_DATA_W-1:0]  core_l15_data,
    input  logic                      l15_core_ack,
    input  logic                      l15_core_header_ack,
    // l1.5 response
    input  logic                      l15_core_val,
    input  logic [`PITON_RTYPE_W-1:0] l15_core_returntype,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_0,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_1,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_2,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_3
);

    piton_pkg::rqtype_e       enc_rqtype;
    piton_pkg::msg_size_e     enc_size;
    logic [`PITON_DATA_W-1:0] enc_data;
    logic [`PITON_DATA_W-1:0] resp_word;
    logic                     resp_err;

    piton_req_encoder u_piton_req_encoder (
        .bw       (bw),
        .rd       (rd),
        .wdata    (wdata),
        .rqtype   (enc_rqtype),
        .size     (enc_size),
        .l15_data (enc_data)
    );

    piton_core_bridge u_piton_core_bridge (
        .clk (clk), .nrst (nrst), .op (op), .addr (addr),
        .enc_rqtype (enc_rqtype), .enc_size (enc_size), .enc_data (enc_data),
        .l15_core_ack (l15_core_ack), .l15_core_header_ack (l15_core_header_ack),
        .l15_core_val (l15_core_val), .resp_word (resp_word), .resp_err (resp_err),
        .core_l15_val (core_l15_val), .core_l15_rqtype (core_l15_rqtype),
        .core_l15_size (core_l15_size), .core_l15_address (core_l15_address),
        .core_l15_data (core_l15_data), .rdata (rdata), .done (done), .err (err)
    );

    // word offset within the 16-byte line comes from the held address
    piton_resp_unpack u_piton_resp_unpack (
        .word_sel            (core_l15_address[3:2]),
        .l15_core_returntype (l15_core_returntype),
        .l15_core_data_0     (l15_core_data_0),
        .l15_core_data_1     (l15_core_data_1),
        .l15_core_data_2     (l15_core_data_2),
        .l15_core_data_3     (l15_core_data_3),
        .word                (resp_word),
        .is_err              (resp_err)
    );

endmodule

// ==== source/piton_pkg.sv ====
// request type, return type, message size and bridge state enums
`include "piton_config.svh"

package piton_pkg;

    // only plain loads and stores are issued
    typedef enum logic [`PITON_RQTYPE_W-1:0] {
        LOAD_RQ  = 6'd0,
        STORE_RQ = 6'd1
    } rqtype_e;

    // full return code space, only load, store ack and error are acted on
    typedef enum logic [`PITON_RTYPE_W-1:0] {
        LOAD_RET    = 4'd0,
        IFILL_RET   = 4'd1,
        STRLOAD_RET = 4'd2,
        INV_RET     = 4'd3,
        ST_ACK      = 4'd4,
        TEST_RET    = 4'd5,
        STRST_ACK   = 4'd6,
        INT_RET     = 4'd7,
        FP_RET      = 4'd8,
        FWD_RQ_RET  = 4'd10,
        FWD_RPY_RET = 4'd11,
        ERR_RET     = 4'd12,
        RSVD_RET    = 4'd15
    } rettype_e;

    // message data size, larger sizes never used by a 32-bit core
    typedef enum logic [`PITON_SIZE_W-1:0] {
        SIZE_0B = 3'd0,
        SIZE_1B = 3'd1,
        SIZE_2B = 3'd2,
        SIZE_4B = 3'd3
    } msg_size_e;

    // S_REQ is the idle state waiting for a core op
    typedef enum logic [1:0] {
        S_REQ  = 2'd0,
        S_SEND = 2'd1,
        S_WAIT = 2'd2,
        S_RESP = 2'd3
    } bridge_state_e;

endpackage

// ==== source/piton_req_encoder.sv ====
// request encoder: request type, message size and big-endian store data
`include "piton_config.svh"

module piton_req_encoder (
    input  logic [`PITON_BE_W-1:0]   bw,
    input  logic                     rd,
    input  logic [`PITON_DATA_W-1:0] wdata,
    output piton_pkg::rqtype_e       rqtype,
    output piton_pkg::msg_size_e     size,
    output logic [`PITON_DATA_W-1:0] l15_data
);

    // core is little-endian, l1.5 expects big-endian payload
    assign l15_data = {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};

    always_comb begin
        if (bw != '0) begin
            rqtype = piton_pkg::STORE_RQ;
            case (bw)
                4'b1111: begin
                    size = piton_pkg::SIZE_4B;
                end
                4'b0011, 4'b1100: begin
                    size = piton_pkg::SIZE_2B;
                end
                4'b0001, 4'b0010, 4'b0100, 4'b1000: begin
                    size = piton_pkg::SIZE_1B;
                end
                default: begin
                    // scattered byte mask, no matching message size
                    size = piton_pkg::SIZE_0B;
                end
            endcase
        end else begin
            rqtype = piton_pkg::LOAD_RQ;
            // loads always fetch the full word
            if (rd) begin
                size = piton_pkg::SIZE_4B;
            end else begin
                size = piton_pkg::SIZE_0B;
            end
        end
    end

endmodule

// ==== source/piton_resp_unpack.sv ====
// response unpacker: word select, byte swap, error return detection
`include "piton_config.svh"

module piton_resp_unpack (
    input  logic [1:0]                word_sel,
    input  logic [`PITON_RTYPE_W-1:0] l15_core_returntype,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_0,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_1,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_2,
    input  logic [`PITON_DATA_W-1:0]  l15_core_data_3,
    output logic [`PITON_DATA_W-1:0]  word,
    output logic                      is_err
);

    logic [`PITON_DATA_W-1:0] be_word;

    // data_0 carries line offset 0
    always_comb begin
        case (word_sel)
            2'd0: begin
                be_word = l15_core_data_0;
            end
            2'd1: begin
                be_word = l15_core_data_1;
            end
            2'd2: begin
                be_word = l15_core_data_2;
            end
            default: begin
                be_word = l15_core_data_3;
            end
        endcase
    end

    // back to core byte order
    assign word = {be_word[7:0], be_word[15:8], be_word[23:16], be_word[31:24]};

    assign is_err = (l15_core_returntype == piton_pkg::ERR_RET);

endmodule

// ==== verilog.f ====
+incdir+source
source/piton_pkg.sv
source/piton_req_encoder.sv
source/piton_resp_unpack.sv
source/piton_core_bridge.sv
source/piton_core_top.sv
dv/piton_clk_gen.sv
dv/piton_bridge_assert.sv
dv/piton_tb.sv
